/* hw/tscPkg.sv */
package tscPkg;

	// Word width shared by data, addresses and instructions
	localparam int WORD_SIZE = 16;
	localparam int NUM_REGS = 4;

	// JAL and JRL save the return address here
	localparam logic [1:0] LINK_REG = 2'd2;

	// Major opcodes in inst[15:12]
	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_JMP = 4'd9,
		OP_JAL = 4'd10,
		OP_RTYPE = 4'd15
	} opcodeT;

	// R-type function codes in inst[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funcT;

	// One instruction word, three decodings
	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			funcT func;
		} rType;
		struct packed {
			opcodeT opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm8;
		} iType;
		struct packed {
			opcodeT opcode;
			logic [11:0] target12;
		} jType;
	} instT;

	// Sequencer states
	typedef enum logic [2:0] {
		ST_IF,
		ST_ID,
		ST_EX1,
		ST_EX2,
		ST_MEM,
		ST_WB,
		ST_HLT
	} ctrlStateT;

	// Write-back data source
	typedef enum logic [1:0] {
		WD_ALU,
		WD_MEM,
		WD_PC
	} wrDataSelT;

	// Destination register select
	typedef enum logic [1:0] {
		WR_RT,
		WR_RD,
		WR_LINK
	} wrRegSelT;

endpackage

/* hw/memBus.sv */
`timescale 1ns/1ps

interface memBus;
	import tscPkg::*;

	// Request side held stable while req is high
	logic req;
	logic we;
	logic [WORD_SIZE-1:0] addr;
	logic [WORD_SIZE-1:0] wdata;

	// Response side with rdata valid while ack is high on a read
	logic ack;
	logic [WORD_SIZE-1:0] rdata;

	// Client end
	modport master (output req, we, addr, wdata, input ack, rdata);

	// Memory end
	modport slave (input req, we, addr, wdata, output ack, rdata);

endinterface

/* hw/microControl.sv */
`timescale 1ns/1ps

module microControl (
	input logic clk,
	input logic reset_n,
	input tscPkg::instT inst,
	input logic fetchDone,
	input logic lsDone,
	input logic branchTaken,
	output logic fetchStart,
	output logic lsStart,
	output logic lsWrite,
	output logic pcWrite,
	output logic regWrite,
	output tscPkg::wrDataSelT wrDataSel,
	output tscPkg::wrRegSelT wrRegSel,
	output logic aluSrc,
	output logic pcSrc1,
	output logic pcSrc2,
	output logic wwdStrobe,
	output logic halted
);
	import tscPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	opcodeT opcode;
	funcT func;
	logic isRtype;
	logic isWwd;
	logic isJpr;
	logic isJrl;
	logic isHlt;
	logic isBranch;
	logic isJump;
	logic isLink;
	logic isMemOp;
	logic takeBranch;
	// Start already sent in the current IF or MEM visit
	logic issued;

	// Instruction class decode
	assign opcode = inst.rType.opcode;
	assign func = inst.rType.func;
	assign isRtype = opcode == OP_RTYPE;
	assign isWwd = isRtype && func == FN_WWD;
	assign isJpr = isRtype && func == FN_JPR;
	assign isJrl = isRtype && func == FN_JRL;
	assign isHlt = isRtype && func == FN_HLT;
	assign isBranch = opcode inside {OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ};
	assign isJump = opcode == OP_JMP || opcode == OP_JAL;
	assign isLink = opcode == OP_JAL || isJrl;
	assign isMemOp = opcode == OP_LWD || opcode == OP_SWD;
	assign takeBranch = isBranch && branchTaken;

	// Datapath selects, static over the instruction
	assign wrDataSel = (opcode == OP_LWD) ? WD_MEM : (isLink ? WD_PC : WD_ALU);
	assign wrRegSel = isLink ? WR_LINK : (isRtype ? WR_RD : WR_RT);
	assign aluSrc = opcode inside {OP_ADI, OP_ORI, OP_LHI, OP_LWD, OP_SWD};
	assign lsWrite = opcode == OP_SWD;

	// Next PC select {pcSrc2, pcSrc1} is 00 PC+1, 01 jump target, 10 rs or 11 branch target
	assign pcSrc1 = isJump || takeBranch;
	assign pcSrc2 = isJpr || isJrl || takeBranch;

	// State paths per instruction class
	always_comb begin
		nextState = state;
		case (state)
			ST_IF: begin
				if (fetchDone) begin
					if (isHlt) nextState = ST_HLT;
					else if (isJump) nextState = ST_EX1;
					else nextState = ST_ID;
				end
			end
			ST_ID: begin
				if (isWwd || isJpr) nextState = ST_IF;
				else if (isJrl) nextState = ST_WB;
				else nextState = ST_EX1;
			end
			ST_EX1: nextState = ST_EX2;
			ST_EX2: begin
				if (isBranch || opcode == OP_JMP) nextState = ST_IF;
				else if (isMemOp) nextState = ST_MEM;
				else nextState = ST_WB;
			end
			ST_MEM: begin
				if (lsDone) nextState = (opcode == OP_SWD) ? ST_IF : ST_WB;
			end
			ST_WB: nextState = ST_IF;
			ST_HLT: nextState = ST_HLT;
			default: nextState = ST_IF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IF;
			issued <= 1'b0;
		end else begin
			state <= nextState;
			// Rearm on every state change
			if (nextState != state) issued <= 1'b0;
			else if (fetchStart || lsStart) issued <= 1'b1;
		end
	end

	// One start pulse per IF or MEM visit
	assign fetchStart = state == ST_IF && !issued;
	assign lsStart = state == ST_MEM && !issued;

	// PC moves on the last cycle before the next IF
	assign pcWrite = nextState == ST_IF && state != ST_IF;
	// Only writing instructions reach WB
	assign regWrite = state == ST_WB;
	assign wwdStrobe = state == ST_ID && isWwd;
	assign halted = state == ST_HLT;

	// Data access only for a load or store that reached MEM
	assert property (@(posedge clk) disable iff (!reset_n)
		lsStart |-> (opcode == OP_LWD || opcode == OP_SWD));

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset_n,
	input tscPkg::instT inst,
	input logic pcWrite,
	input logic regWrite,
	input logic aluSrc,
	input logic pcSrc1,
	input logic pcSrc2,
	input tscPkg::wrDataSelT wrDataSel,
	input tscPkg::wrRegSelT wrRegSel,
	input logic wwdStrobe,
	input logic [tscPkg::WORD_SIZE-1:0] loadData,
	output logic [tscPkg::WORD_SIZE-1:0] pc,
	output logic [tscPkg::WORD_SIZE-1:0] aluResult,
	output logic [tscPkg::WORD_SIZE-1:0] rtValue,
	output logic branchTaken,
	output logic [tscPkg::WORD_SIZE-1:0] outWord,
	output logic outWordValid
);
	import tscPkg::*;

	logic [WORD_SIZE-1:0] regFile [NUM_REGS];
	logic [WORD_SIZE-1:0] rsValue;
	logic [WORD_SIZE-1:0] signImm;
	logic [WORD_SIZE-1:0] zeroImm;
	logic [WORD_SIZE-1:0] operandB;
	logic [WORD_SIZE-1:0] pcPlusOne;
	logic [WORD_SIZE-1:0] pcNext;
	logic [WORD_SIZE-1:0] wrData;
	logic [1:0] wrAddr;

	// Register reads
	assign rsValue = regFile[inst.rType.rs];
	assign rtValue = regFile[inst.rType.rt];

	// ORI takes imm8 zero-extended and the rest sign-extended
	assign signImm = {{8{inst.iType.imm8[7]}}, inst.iType.imm8};
	assign zeroImm = {8'h00, inst.iType.imm8};
	assign operandB = aluSrc ? ((inst.iType.opcode == OP_ORI) ? zeroImm : signImm) : rtValue;

	// ALU adds by default for ADI and load/store addressing
	always_comb begin
		aluResult = rsValue + operandB;
		case (inst.rType.opcode)
			OP_ORI: aluResult = rsValue | operandB;
			OP_LHI: aluResult = {inst.iType.imm8, 8'h00};
			OP_RTYPE: begin
				case (inst.rType.func)
					FN_SUB: aluResult = rsValue - operandB;
					FN_AND: aluResult = rsValue & operandB;
					FN_ORR: aluResult = rsValue | operandB;
					FN_NOT: aluResult = ~rsValue;
					FN_TCP: aluResult = ~rsValue + 1'b1;
					FN_SHL: aluResult = rsValue << 1;
					// Arithmetic shift keeps the sign
					FN_SHR: aluResult = {rsValue[WORD_SIZE-1], rsValue[WORD_SIZE-1:1]};
					default: aluResult = rsValue + operandB;
				endcase
			end
			default: aluResult = rsValue + operandB;
		endcase
	end

	// Branch condition for the four branch opcodes
	always_comb begin
		case (inst.rType.opcode)
			OP_BNE: branchTaken = rsValue != rtValue;
			OP_BEQ: branchTaken = rsValue == rtValue;
			OP_BGZ: branchTaken = $signed(rsValue) > 0;
			OP_BLZ: branchTaken = $signed(rsValue) < 0;
			default: branchTaken = 1'b0;
		endcase
	end

	// Next PC source
	assign pcPlusOne = pc + 1'b1;
	always_comb begin
		case ({pcSrc2, pcSrc1})
			2'b01: pcNext = {pc[WORD_SIZE-1:12], inst.jType.target12};
			2'b10: pcNext = rsValue;
			2'b11: pcNext = pcPlusOne + signImm;
			default: pcNext = pcPlusOne;
		endcase
	end

	// Write-back source and destination
	always_comb begin
		case (wrDataSel)
			WD_MEM: wrData = loadData;
			WD_PC: wrData = pcPlusOne;
			default: wrData = aluResult;
		endcase
		case (wrRegSel)
			WR_RD: wrAddr = inst.rType.rd;
			WR_LINK: wrAddr = LINK_REG;
			default: wrAddr = inst.rType.rt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			outWordValid <= 1'b0;
		end else begin
			if (pcWrite) pc <= pcNext;
			outWordValid <= wwdStrobe;
		end
	end

	always_ff @(posedge clk) begin
		if (regWrite) regFile[wrAddr] <= wrData;
		// WWD shows rs
		if (wwdStrobe) outWord <= rsValue;
	end

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
	input logic clk,
	input logic reset_n,
	input logic fetchStart,
	input logic [tscPkg::WORD_SIZE-1:0] pc,
	output tscPkg::instT inst,
	output logic fetchDone,
	memBus.master bus
);
	logic reqOut;
	// Req dropped and waiting for ack to fall
	logic waitLow;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reqOut <= 1'b0;
			waitLow <= 1'b0;
			fetchDone <= 1'b0;
		end else begin
			fetchDone <= 1'b0;
			if (fetchStart) begin
				reqOut <= 1'b1;
			end else if (reqOut && bus.ack) begin
				reqOut <= 1'b0;
				waitLow <= 1'b1;
			end else if (waitLow && !bus.ack) begin
				waitLow <= 1'b0;
				fetchDone <= 1'b1;
			end
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (reqOut && bus.ack) inst <= bus.rdata;
	end

	// PC holds until the instruction ends
	assign bus.req = reqOut;
	assign bus.we = 1'b0;
	assign bus.addr = pc;
	assign bus.wdata = '0;

	assert property (@(posedge clk) disable iff (!reset_n)
		fetchStart |-> !(reqOut || waitLow));

endmodule

/* hw/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
	input logic clk,
	input logic reset_n,
	input logic lsStart,
	input logic lsWrite,
	input logic [tscPkg::WORD_SIZE-1:0] aluResult,
	input logic [tscPkg::WORD_SIZE-1:0] rtValue,
	output logic [tscPkg::WORD_SIZE-1:0] loadData,
	output logic lsDone,
	memBus.master bus
);
	import tscPkg::*;

	logic reqOut;
	logic waitLow;
	logic weReg;
	logic [WORD_SIZE-1:0] addrReg;
	logic [WORD_SIZE-1:0] dataReg;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reqOut <= 1'b0;
			waitLow <= 1'b0;
			lsDone <= 1'b0;
		end else begin
			lsDone <= 1'b0;
			if (lsStart) begin
				reqOut <= 1'b1;
			end else if (reqOut && bus.ack) begin
				reqOut <= 1'b0;
				waitLow <= 1'b1;
			end else if (waitLow && !bus.ack) begin
				waitLow <= 1'b0;
				lsDone <= 1'b1;
			end
		end
	end

	// Request fields frozen for the whole handshake
	always_ff @(posedge clk) begin
		if (lsStart) begin
			weReg <= lsWrite;
			addrReg <= aluResult;
			dataReg <= rtValue;
		end
		// Load data captured while ack is high
		if (reqOut && bus.ack && !weReg) loadData <= bus.rdata;
	end

	assign bus.req = reqOut;
	assign bus.we = weReg;
	assign bus.addr = addrReg;
	assign bus.wdata = dataReg;

	assert property (@(posedge clk) disable iff (!reset_n)
		lsStart |-> !(reqOut || waitLow));

endmodule

/* hw/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
	input logic clk,
	input logic reset_n,
	memBus.slave fetchBus,
	memBus.slave dataBus,
	memBus.master memBus
);
	// Locked grants held until the handshake fully closes
	logic grantFetch;
	logic grantData;
	// Effective grants valid in the same cycle as a fresh req
	logic useFetch;
	logic useData;

	// Data wins when both ask in the same cycle
	assign useData = grantData || (!grantFetch && dataBus.req);
	assign useFetch = grantFetch || (!grantData && !dataBus.req && fetchBus.req);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			grantFetch <= 1'b0;
			grantData <= 1'b0;
		end else if (!grantFetch && !grantData) begin
			grantData <= dataBus.req;
			grantFetch <= !dataBus.req && fetchBus.req;
		end else if (!memBus.req && !memBus.ack) begin
			// Release once req and ack are both low
			grantFetch <= 1'b0;
			grantData <= 1'b0;
		end
	end

	// Downstream request mux
	always_comb begin
		memBus.req = 1'b0;
		memBus.we = fetchBus.we;
		memBus.addr = fetchBus.addr;
		memBus.wdata = fetchBus.wdata;
		if (useData) begin
			memBus.req = dataBus.req;
			memBus.we = dataBus.we;
			memBus.addr = dataBus.addr;
			memBus.wdata = dataBus.wdata;
		end else if (useFetch) begin
			memBus.req = fetchBus.req;
		end
	end

	// Response only to the granted client
	assign fetchBus.ack = useFetch && memBus.ack;
	assign dataBus.ack = useData && memBus.ack;
	assign fetchBus.rdata = useFetch ? memBus.rdata : '0;
	assign dataBus.rdata = useData ? memBus.rdata : '0;

	// Any ack from memory belongs to exactly one locked grant
	assert property (@(posedge clk) disable iff (!reset_n)
		memBus.ack |-> (grantFetch ^ grantData));

endmodule

/* hw/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic reset_n,
	input logic memAck,
	input logic [tscPkg::WORD_SIZE-1:0] memRdata,
	output logic memReq,
	output logic memWe,
	output logic [tscPkg::WORD_SIZE-1:0] memAddr,
	output logic [tscPkg::WORD_SIZE-1:0] memWdata,
	output logic [tscPkg::WORD_SIZE-1:0] outWord,
	output logic outWordValid,
	output logic halted
);
	import tscPkg::*;

	memBus fetchBus ();
	memBus dataBus ();
	memBus extBus ();

	instT inst;
	wrDataSelT wrDataSel;
	wrRegSelT wrRegSel;
	logic fetchStart, fetchDone, lsStart, lsWrite, lsDone;
	logic pcWrite, regWrite, aluSrc, pcSrc1, pcSrc2, wwdStrobe, branchTaken;
	logic [WORD_SIZE-1:0] pc, aluResult, rtValue, loadData;

	microControl u_microControl (
		.clk, .reset_n, .inst, .fetchDone, .lsDone, .branchTaken,
		.fetchStart, .lsStart, .lsWrite, .pcWrite, .regWrite,
		.wrDataSel, .wrRegSel, .aluSrc, .pcSrc1, .pcSrc2, .wwdStrobe, .halted
	);

	datapath u_datapath (
		.clk, .reset_n, .inst, .pcWrite, .regWrite, .aluSrc, .pcSrc1, .pcSrc2,
		.wrDataSel, .wrRegSel, .wwdStrobe, .loadData,
		.pc, .aluResult, .rtValue, .branchTaken, .outWord, .outWordValid
	);

	fetchUnit u_fetchUnit (.clk, .reset_n, .fetchStart, .pc, .inst, .fetchDone, .bus(fetchBus));

	loadStoreUnit u_loadStoreUnit (
		.clk, .reset_n, .lsStart, .lsWrite, .aluResult, .rtValue,
		.loadData, .lsDone, .bus(dataBus)
	);

	memArbiter u_memArbiter (.clk, .reset_n, .fetchBus, .dataBus, .memBus(extBus));

	// External memory port
	assign memReq = extBus.req;
	assign memWe = extBus.we;
	assign memAddr = extBus.addr;
	assign memWdata = extBus.wdata;
	assign extBus.ack = memAck;
	assign extBus.rdata = memRdata;

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset_n
);
	localparam int PERIOD_NS = 4;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		reset_n <= 1'b0;
		// Low across the first three rising edges
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* testbench/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;
	import tscPkg::*;

	localparam int CLK_PERIOD_NS = 4;
	// Budget per instruction covers fetch, load and worst ack delay
	localparam int MAX_INSTR = 300;
	localparam int CYCLES_PER_INSTR = 25;
	localparam int WATCHDOG_NS = MAX_INSTR * CYCLES_PER_INSTR * CLK_PERIOD_NS;
	localparam int QUIET_CYCLES = 40;
	localparam logic [7:0] DATA_BASE = 8'h60;

	logic clk;
	logic reset_n;
	logic memReq;
	logic memWe;
	logic [15:0] memAddr;
	logic [15:0] memWdata;
	logic memAck;
	logic [15:0] memRdata;
	logic [15:0] outWord;
	logic outWordValid;
	logic halted;

	// Memory model contents and the reference copy
	logic [15:0] mem [0:255];
	logic [15:0] progImage [0:255];
	logic [15:0] refMem [0:255];
	logic [15:0] expWwd [$];
	logic [15:0] expPc [$];
	int ackDelay;
	int seed = 32'he5129222;

	clockGen u_clockGen (.clk, .reset_n);

	cpuTop u_cpuTop (
		.clk,
		.reset_n,
		.memAck,
		.memRdata,
		.memReq,
		.memWe,
		.memAddr,
		.memWdata,
		.outWord,
		.outWordValid,
		.halted
	);

	initial begin
		memAck <= 1'b0;
		memRdata <= 16'h0000;
		ackDelay <= 0;
	end

	// Four-phase slave acking after 0 to 3 random cycles
	always @(posedge clk) begin
		if (!reset_n) begin
			memAck <= 1'b0;
			memRdata <= 16'h0000;
			ackDelay <= $random(seed) & 3;
			for (int i = 0; i < 256; i++) begin
				mem[i] <= progImage[i];
			end
		end else if (memAck) begin
			// Close the handshake once req is gone
			if (!memReq) begin
				memAck <= 1'b0;
				ackDelay <= $random(seed) & 3;
			end
		end else if (memReq) begin
			if (ackDelay == 0) begin
				memAck <= 1'b1;
				if (memWe) mem[memAddr[7:0]] <= memWdata;
				else memRdata <= mem[memAddr[7:0]];
			end else begin
				ackDelay <= ackDelay - 1;
			end
		end
	end

	// Instruction encoders
	function automatic logic [15:0] rInst(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input funcT fn);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iInst(input opcodeT op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jInst(input opcodeT op, input logic [11:0] target);
		return {op, target};
	endfunction

	function automatic void buildProgram();
		// Data area pattern from the full address
		for (int i = 0; i < 256; i++) begin
			progImage[i] = {i[7:0], ~i[7:0]};
		end
		// Holes in the code show r3 so a stray path breaks the WWD list
		for (int i = 0; i < 80; i++) begin
			progImage[i] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		end
		// Immediates with ORI zero-extending
		progImage[0] = iInst(OP_LHI, 2'd0, 2'd0, 8'h12);
		progImage[1] = iInst(OP_ORI, 2'd0, 2'd0, 8'h34);
		progImage[2] = rInst(2'd0, 2'd0, 2'd0, FN_WWD);
		progImage[3] = iInst(OP_LHI, 2'd0, 2'd1, 8'h00);
		progImage[4] = iInst(OP_ADI, 2'd1, 2'd1, 8'hFB);
		progImage[5] = rInst(2'd1, 2'd0, 2'd0, FN_WWD);
		progImage[6] = iInst(OP_ORI, 2'd0, 2'd2, 8'hC0);
		progImage[7] = rInst(2'd2, 2'd0, 2'd0, FN_WWD);
		// R-type ALU into r3
		progImage[8] = rInst(2'd0, 2'd1, 2'd3, FN_ADD);
		progImage[9] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[10] = rInst(2'd0, 2'd1, 2'd3, FN_SUB);
		progImage[11] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[12] = rInst(2'd0, 2'd2, 2'd3, FN_AND);
		progImage[13] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[14] = rInst(2'd1, 2'd0, 2'd3, FN_ORR);
		progImage[15] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[16] = rInst(2'd0, 2'd0, 2'd3, FN_NOT);
		progImage[17] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[18] = rInst(2'd1, 2'd0, 2'd3, FN_TCP);
		progImage[19] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[20] = rInst(2'd0, 2'd0, 2'd3, FN_SHL);
		progImage[21] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[22] = rInst(2'd1, 2'd0, 2'd3, FN_SHR);
		progImage[23] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		// Store then load back through base r3
		progImage[24] = iInst(OP_LHI, 2'd0, 2'd3, 8'h00);
		progImage[25] = iInst(OP_ADI, 2'd3, 2'd3, DATA_BASE);
		progImage[26] = iInst(OP_SWD, 2'd3, 2'd0, 8'h00);
		progImage[27] = iInst(OP_SWD, 2'd3, 2'd1, 8'h01);
		progImage[28] = iInst(OP_LWD, 2'd3, 2'd2, 8'h00);
		progImage[29] = rInst(2'd2, 2'd0, 2'd0, FN_WWD);
		progImage[30] = iInst(OP_LWD, 2'd3, 2'd2, 8'h01);
		progImage[31] = rInst(2'd2, 2'd0, 2'd0, FN_WWD);
		// Branches taken and not taken
		progImage[32] = iInst(OP_BNE, 2'd1, 2'd2, 8'h02);
		progImage[33] = rInst(2'd0, 2'd0, 2'd0, FN_WWD);
		progImage[34] = iInst(OP_BEQ, 2'd1, 2'd2, 8'h01);
		progImage[36] = iInst(OP_BNE, 2'd0, 2'd1, 8'h01);
		progImage[38] = iInst(OP_BGZ, 2'd0, 2'd0, 8'h01);
		progImage[40] = iInst(OP_BGZ, 2'd1, 2'd0, 8'h01);
		progImage[41] = rInst(2'd1, 2'd0, 2'd0, FN_WWD);
		progImage[42] = iInst(OP_BLZ, 2'd1, 2'd0, 8'h01);
		progImage[44] = iInst(OP_BLZ, 2'd0, 2'd0, 8'h01);
		progImage[45] = iInst(OP_BEQ, 2'd0, 2'd1, 8'h01);
		// Count-down loop on a backward BGZ
		progImage[46] = iInst(OP_LHI, 2'd0, 2'd3, 8'h00);
		progImage[47] = iInst(OP_ADI, 2'd3, 2'd3, 8'h03);
		progImage[48] = rInst(2'd3, 2'd0, 2'd0, FN_WWD);
		progImage[49] = iInst(OP_ADI, 2'd3, 2'd3, 8'hFF);
		progImage[50] = iInst(OP_BGZ, 2'd3, 2'd0, 8'hFD);
		// Jumps and links
		progImage[51] = jInst(OP_JMP, 12'd54);
		progImage[54] = jInst(OP_JAL, 12'd60);
		progImage[60] = rInst(2'd2, 2'd0, 2'd0, FN_WWD);
		progImage[61] = iInst(OP_LHI, 2'd0, 2'd1, 8'h00);
		progImage[62] = iInst(OP_ADI, 2'd1, 2'd1, 8'd66);
		progImage[63] = rInst(2'd1, 2'd0, 2'd0, FN_JRL);
		progImage[66] = rInst(2'd2, 2'd0, 2'd0, FN_WWD);
		progImage[67] = iInst(OP_LHI, 2'd0, 2'd0, 8'h00);
		progImage[68] = iInst(OP_ADI, 2'd0, 2'd0, 8'd72);
		progImage[69] = rInst(2'd0, 2'd0, 2'd0, FN_JPR);
		progImage[72] = rInst(2'd0, 2'd0, 2'd0, FN_WWD);
		progImage[73] = rInst(2'd0, 2'd0, 2'd0, FN_HLT);
	endfunction

	// ISA model runs on the copy and fills expWwd and refMem
	function automatic void refRun();
		logic [15:0] regs [0:3];
		logic [15:0] pc;
		logic [15:0] curPc;
		logic [15:0] ir;
		logic [15:0] rsVal;
		logic [15:0] rtVal;
		logic [15:0] sImm;
		logic [15:0] zImm;
		logic [15:0] addr;
		logic [1:0] rt;
		logic [1:0] rd;
		int steps;
		bit running;
		for (int i = 0; i < 256; i++) begin
			refMem[i] = progImage[i];
		end
		for (int r = 0; r < 4; r++) begin
			regs[r] = 16'h0000;
		end
		expWwd.delete();
		expPc.delete();
		pc = 16'h0000;
		running = 1'b1;
		steps = 0;
		while (running && steps < MAX_INSTR) begin
			curPc = pc;
			ir = refMem[pc[7:0]];
			rsVal = regs[ir[11:10]];
			rtVal = regs[ir[9:8]];
			rt = ir[9:8];
			rd = ir[7:6];
			sImm = {{8{ir[7]}}, ir[7:0]};
			zImm = {8'h00, ir[7:0]};
			addr = rsVal + sImm;
			pc = curPc + 16'd1;
			case (ir[15:12])
				// Branch target is PC+1+imm
				OP_BNE: if (rsVal != rtVal) pc = pc + sImm;
				OP_BEQ: if (rsVal == rtVal) pc = pc + sImm;
				OP_BGZ: if (!rsVal[15] && rsVal != 16'h0000) pc = pc + sImm;
				OP_BLZ: if (rsVal[15]) pc = pc + sImm;
				OP_ADI: regs[rt] = rsVal + sImm;
				OP_ORI: regs[rt] = rsVal | zImm;
				OP_LHI: regs[rt] = {ir[7:0], 8'h00};
				OP_LWD: regs[rt] = refMem[addr[7:0]];
				OP_SWD: refMem[addr[7:0]] = rtVal;
				OP_JMP: pc = {curPc[15:12], ir[11:0]};
				OP_JAL: begin
					regs[LINK_REG] = pc;
					pc = {curPc[15:12], ir[11:0]};
				end
				OP_RTYPE: begin
					case (ir[5:0])
						FN_ADD: regs[rd] = rsVal + rtVal;
						FN_SUB: regs[rd] = rsVal - rtVal;
						FN_AND: regs[rd] = rsVal & rtVal;
						FN_ORR: regs[rd] = rsVal | rtVal;
						FN_NOT: regs[rd] = ~rsVal;
						FN_TCP: regs[rd] = 16'd0 - rsVal;
						FN_SHL: regs[rd] = rsVal << 1;
						// Arithmetic right shift
						FN_SHR: regs[rd] = 16'($signed(rsVal) >>> 1);
						FN_WWD: begin
							expWwd.push_back(rsVal);
							expPc.push_back(curPc);
						end
						FN_JPR: pc = rsVal;
						FN_JRL: begin
							regs[LINK_REG] = pc;
							pc = rsVal;
						end
						default: running = 1'b0;
					endcase
				end
				default: running = 1'b0;
			endcase
			steps++;
		end
	endfunction

	task automatic checkValue(input string testName, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h actual %h", testName, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// WWD stream then halt behavior and final memory
	initial begin : compareOutputs
		int wwdIndex;
		buildProgram();
		refRun();
		wwdIndex = 0;
		wait (reset_n === 1'b1);
		while (!halted) begin
			// Outputs settle by the falling edge
			@(negedge clk);
			if (outWordValid) begin
				if (wwdIndex >= expWwd.size()) begin
					$display("WWD output appeared beyond the end of the expected sequence");
					$display("Checks failed");
					$fatal(1);
				end
				checkValue($sformatf("WWD %0d at pc %0d", wwdIndex, expPc[wwdIndex]),
					expWwd[wwdIndex], outWord);
				wwdIndex++;
			end
		end
		checkValue("WWD count", 16'(expWwd.size()), 16'(wwdIndex));
		// No bus or output activity once halted
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (memReq || outWordValid || !halted) begin
				$display("Memory request, WWD output or halt loss seen after HLT");
				$display("Checks failed");
				$fatal(1);
			end
		end
		checkValue("store word 0", refMem[DATA_BASE], mem[DATA_BASE]);
		checkValue("store word 1", refMem[DATA_BASE + 8'd1], mem[DATA_BASE + 8'd1]);
		checkValue("word past stores", refMem[DATA_BASE + 8'd2], mem[DATA_BASE + 8'd2]);
		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the processor never halted within the instruction budget");
		$display("Checks failed");
		$fatal(1);
	end

endmodule

/* files.f */
hw/tscPkg.sv
hw/memBus.sv
hw/microControl.sv
hw/datapath.sv
hw/fetchUnit.sv
hw/loadStoreUnit.sv
hw/memArbiter.sv
hw/cpuTop.sv
testbench/clockGen.sv
testbench/tbCpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tbCpu -f files.f -o simCpu

# Keep the output even when the simulation exits with an error
output=$(./obj_dir/simCpu 2>&1 || true)
echo "$output"

# Pass only when the pass line is present
echo "$output" | grep -qx "All checks passed"
